// File: hdl/nids_settings.svh
`ifndef NIDS_SETTINGS_SVH
`define NIDS_SETTINGS_SVH

// Stream slots held by each context memory
`define NIDS_NUM_STREAMS 64

// Width of a stream identifier
// Must cover NIDS_NUM_STREAMS slots
`define NIDS_STREAM_BITS 6

// Matcher state width
// Holds DFA states 0 to 5
`define NIDS_STATE_BITS 3

// Width of every packet counter
`define NIDS_COUNT_BITS 16

`endif

// File: hdl/nids_pkg.sv
`default_nettype none

`include "nids_settings.svh"

package nids_pkg;

   // One payload byte from the stream
   typedef logic [7:0] char_t;

   // Stream slot index
   typedef logic [`NIDS_STREAM_BITS-1:0] stream_id_t;

   // Matcher state as saved per stream
   typedef logic [`NIDS_STATE_BITS-1:0] dfa_state_t;

   // Packet counter that wraps on overflow
   typedef logic [`NIDS_COUNT_BITS-1:0] count_t;

   // Fold lower case ASCII letters onto upper case
   // Every other byte passes unchanged
   function automatic char_t fold_case(input char_t c);
      if (c >= 8'h61 && c <= 8'h7a)
         return c - 8'h20;
      return c;
   endfunction

endpackage

`default_nettype wire

// File: hdl/pop3_user_dfa.sv
`timescale 1ns/1ps
`default_nettype none

module pop3_user_dfa (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire nids_pkg::char_t       char_in,
   input  wire                        char_in_vld,
   input  wire nids_pkg::dfa_state_t  state_in,
   input  wire                        state_in_vld,
   output nids_pkg::dfa_state_t       state_out,
   output logic                       accept_out
);
   import nids_pkg::*;

   // Index of the last pattern character
   localparam dfa_state_t FINAL_STATE = dfa_state_t'(4);

   dfa_state_t state;
   dfa_state_t next_state;
   char_t      upper;
   char_t      expect_char;
   logic       accept_next;

   // Case insensitive compare
   assign upper = fold_case(char_in);

   // Character expected in each state of "USER "
   always_comb
   begin
      case (state)
         dfa_state_t'(0): expect_char = "U";
         dfa_state_t'(1): expect_char = "S";
         dfa_state_t'(2): expect_char = "E";
         dfa_state_t'(3): expect_char = "R";
         default:         expect_char = " ";
      endcase
   end

   always_comb
   begin
      next_state  = state;
      accept_next = 1'b0;
      if (char_in_vld)
      begin
         if (upper == expect_char && state <= FINAL_STATE)
         begin
            // Full pattern seen so restart after the pulse
            if (state == FINAL_STATE)
            begin
               next_state  = '0;
               accept_next = 1'b1;
            end
            else
               next_state = state + dfa_state_t'(1);
         end
         // A stray U may begin a fresh match
         else if (upper == "U")
            next_state = dfa_state_t'(1);
         else
            next_state = '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state      <= '0;
         accept_out <= 1'b0;
      end
      // Restore from the context wins over any byte
      else if (state_in_vld)
      begin
         state      <= state_in;
         accept_out <= 1'b0;
      end
      else
      begin
         state      <= next_state;
         accept_out <= accept_next;
      end
   end

   assign state_out = state;

   // Context load and payload byte must keep one idle cycle apart
   a_load_no_byte: assert property (@(posedge clk) disable iff (!rst_n)
      !(state_in_vld && char_in_vld));

endmodule

`default_nettype wire

// File: hdl/pop3_pass_dfa.sv
`timescale 1ns/1ps
`default_nettype none

module pop3_pass_dfa (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire nids_pkg::char_t       char_in,
   input  wire                        char_in_vld,
   input  wire nids_pkg::dfa_state_t  state_in,
   input  wire                        state_in_vld,
   output nids_pkg::dfa_state_t       state_out,
   output logic                       accept_out
);
   import nids_pkg::*;

   // Index of the last pattern character
   localparam dfa_state_t FINAL_STATE = dfa_state_t'(4);

   dfa_state_t state;
   dfa_state_t next_state;
   char_t      upper;
   char_t      expect_char;
   logic       accept_next;

   assign upper = fold_case(char_in);

   // Character expected in each state of "PASS "
   always_comb
   begin
      case (state)
         dfa_state_t'(0): expect_char = "P";
         dfa_state_t'(1): expect_char = "A";
         dfa_state_t'(2): expect_char = "S";
         dfa_state_t'(3): expect_char = "S";
         default:         expect_char = " ";
      endcase
   end

   always_comb
   begin
      next_state  = state;
      accept_next = 1'b0;
      if (char_in_vld)
      begin
         if (upper == expect_char && state <= FINAL_STATE)
         begin
            if (state == FINAL_STATE)
            begin
               next_state  = '0;
               accept_next = 1'b1;
            end
            else
               next_state = state + dfa_state_t'(1);
         end
         // Only a P can restart the pattern after a miss
         else if (upper == "P")
            next_state = dfa_state_t'(1);
         else
            next_state = '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state      <= '0;
         accept_out <= 1'b0;
      end
      else if (state_in_vld)
      begin
         state      <= state_in;
         accept_out <= 1'b0;
      end
      else
      begin
         state      <= next_state;
         accept_out <= accept_next;
      end
   end

   assign state_out = state;

   // Restored states come from the context memory and stay in range
   a_state_range: assert property (@(posedge clk) disable iff (!rst_n)
      state_out <= dfa_state_t'(5));

endmodule

`default_nettype wire

// File: hdl/stream_match_context.sv
`timescale 1ns/1ps
`default_nettype none

`include "nids_settings.svh"

module stream_match_context (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        load_state,
   input  wire                        new_stream_id,
   input  wire nids_pkg::stream_id_t  stream_id,
   input  wire                        eop,
   input  wire                        enable,
   input  wire                        accept_out,
   input  wire nids_pkg::dfa_state_t  state_out,
   output nids_pkg::dfa_state_t       state_in,
   output logic                       state_in_vld,
   output nids_pkg::count_t           match_count,
   output logic                       pkt_done,
   output logic                       pkt_hit,
   output nids_pkg::stream_id_t       pkt_stream
);
   import nids_pkg::*;

   // Saved matcher state per stream slot
   dfa_state_t state_mem [0:`NIDS_NUM_STREAMS-1];

   // Stream of the packet in flight
   stream_id_t cur_stream;

   // Set by any accept within the current packet
   logic       match_flag;

   // Memory save and restore
   always_ff @(posedge clk)
   begin
      // Packet start
      if (load_state)
      begin
         // Unknown stream starts from the idle state
         if (new_stream_id)
            state_in <= '0;
         else
            state_in <= state_mem[stream_id];
      end
      // Only an enabled packet leaves its state behind
      if (eop && enable)
         state_mem[cur_stream] <= state_out;
   end

   // Packet payload registers
   always_ff @(posedge clk)
   begin
      if (load_state)
         cur_stream <= stream_id;
      // Stream reported along with pkt_done
      if (eop)
         pkt_stream <= cur_stream;
   end

   // Control state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_in_vld <= 1'b0;
         match_flag   <= 1'b0;
         match_count  <= '0;
         pkt_done     <= 1'b0;
         pkt_hit      <= 1'b0;
      end
      else
      begin
         // Load pulse one cycle after load_state
         state_in_vld <= load_state;
         // Report strobe one cycle after eop
         pkt_done     <= eop;

         // Fresh flag for each packet
         if (load_state)
            match_flag <= 1'b0;
         else if (accept_out)
            match_flag <= 1'b1;
         // Disabled packet throws its result away
         else if (eop && !enable)
            match_flag <= 1'b0;

         if (eop)
         begin
            pkt_hit <= match_flag & enable;
            // Count matching packets while enabled
            if (enable)
               match_count <= match_count + count_t'(match_flag);
         end
      end
   end

   // Packet start and end stay at least a cycle apart
   a_load_eop_apart: assert property (@(posedge clk) disable iff (!rst_n)
      !(load_state && eop));

   // The last accept lands before eop so it is counted
   a_no_accept_at_eop: assert property (@(posedge clk) disable iff (!rst_n)
      !(accept_out && eop));

endmodule

`default_nettype wire

// File: hdl/login_alert_combiner.sv
`timescale 1ns/1ps
`default_nettype none

module login_alert_combiner (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        user_done,
   input  wire                        user_hit,
   input  wire nids_pkg::stream_id_t  user_stream,
   input  wire                        pass_done,
   input  wire                        pass_hit,
   input  wire nids_pkg::stream_id_t  pass_stream,
   output logic                       login_alert,
   output nids_pkg::stream_id_t       alert_stream,
   output nids_pkg::count_t           login_count
);
   import nids_pkg::*;

   // Both commands seen within one packet
   logic login_hit;

   assign login_hit = user_done && pass_done && user_hit && pass_hit;

   // Alert pulse and login counter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         login_alert <= 1'b0;
         login_count <= '0;
      end
      else
      begin
         login_alert <= login_hit;
         // Wraps like the other counters
         if (login_hit)
            login_count <= login_count + count_t'(1);
      end
   end

   // Stream of the last reported packet
   // Valid whenever login_alert is high
   always_ff @(posedge clk)
   begin
      if (user_done)
         alert_stream <= user_stream;
   end

   // Both contexts see the same strobes
   a_done_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      user_done == pass_done);

   // Reports of one packet carry one stream
   a_stream_agree: assert property (@(posedge clk) disable iff (!rst_n)
      user_done |-> user_stream == pass_stream);

endmodule

`default_nettype wire

// File: hdl/pop3_login_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module pop3_login_monitor (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire nids_pkg::char_t       char_in,
   input  wire                        char_in_vld,
   input  wire                        load_state,
   input  wire                        new_stream_id,
   input  wire nids_pkg::stream_id_t  stream_id,
   input  wire                        eop,
   input  wire                        user_enable,
   input  wire                        pass_enable,
   output wire nids_pkg::count_t      user_count,
   output wire nids_pkg::count_t      pass_count,
   output wire                        login_alert,
   output wire nids_pkg::stream_id_t  alert_stream,
   output wire nids_pkg::count_t      login_count
);
   import nids_pkg::*;

   // USER matcher and its context
   dfa_state_t user_state_in;
   dfa_state_t user_state_out;
   wire        user_state_in_vld;
   wire        user_accept;
   wire        user_done;
   wire        user_hit;
   stream_id_t user_stream;

   // PASS matcher and its context
   dfa_state_t pass_state_in;
   dfa_state_t pass_state_out;
   wire        pass_state_in_vld;
   wire        pass_accept;
   wire        pass_done;
   wire        pass_hit;
   stream_id_t pass_stream;

   pop3_user_dfa u_user_dfa (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (char_in),
      .char_in_vld  (char_in_vld),
      .state_in     (user_state_in),
      .state_in_vld (user_state_in_vld),
      .state_out    (user_state_out),
      .accept_out   (user_accept)
   );

   pop3_pass_dfa u_pass_dfa (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (char_in),
      .char_in_vld  (char_in_vld),
      .state_in     (pass_state_in),
      .state_in_vld (pass_state_in_vld),
      .state_out    (pass_state_out),
      .accept_out   (pass_accept)
   );

   // Both contexts share the packet strobes
   stream_match_context u_user_ctx (
      .clk (clk), .rst_n (rst_n),
      .load_state (load_state), .new_stream_id (new_stream_id), .stream_id (stream_id),
      .eop (eop), .enable (user_enable),
      .accept_out (user_accept), .state_out (user_state_out),
      .state_in (user_state_in), .state_in_vld (user_state_in_vld),
      .match_count (user_count),
      .pkt_done (user_done), .pkt_hit (user_hit), .pkt_stream (user_stream)
   );

   stream_match_context u_pass_ctx (
      .clk (clk), .rst_n (rst_n),
      .load_state (load_state), .new_stream_id (new_stream_id), .stream_id (stream_id),
      .eop (eop), .enable (pass_enable),
      .accept_out (pass_accept), .state_out (pass_state_out),
      .state_in (pass_state_in), .state_in_vld (pass_state_in_vld),
      .match_count (pass_count),
      .pkt_done (pass_done), .pkt_hit (pass_hit), .pkt_stream (pass_stream)
   );

   // Alert two cycles after eop
   login_alert_combiner u_combiner (
      .clk          (clk),
      .rst_n        (rst_n),
      .user_done    (user_done),
      .user_hit     (user_hit),
      .user_stream  (user_stream),
      .pass_done    (pass_done),
      .pass_hit     (pass_hit),
      .pass_stream  (pass_stream),
      .login_alert  (login_alert),
      .alert_stream (alert_stream),
      .login_count  (login_count)
   );

endmodule

`default_nettype wire

// File: testbench/tb_pop3_login_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "nids_settings.svh"

module tb_pop3_login_monitor;
   import nids_pkg::*;

   localparam int NUM_DIRECTED = 8;
   localparam int NUM_RANDOM   = 300;
   localparam int RESET_CYCLES = 5;
   // Worst random packet stays well below 50 cycles
   localparam int CYCLE_LIMIT  = (NUM_DIRECTED + NUM_RANDOM) * 50 + RESET_CYCLES;

   logic       clk = 1'b0;
   logic       rst_n;
   char_t      char_in;
   logic       char_in_vld;
   logic       load_state;
   logic       new_stream_id;
   stream_id_t stream_id;
   logic       eop;
   logic       user_enable;
   logic       pass_enable;
   count_t     user_count;
   count_t     pass_count;
   logic       login_alert;
   stream_id_t alert_stream;
   count_t     login_count;

   // Reference saved states and which slots hold a written value
   dfa_state_t ref_user_mem [0:`NIDS_NUM_STREAMS-1];
   dfa_state_t ref_pass_mem [0:`NIDS_NUM_STREAMS-1];
   bit         user_saved [0:`NIDS_NUM_STREAMS-1];
   bit         pass_saved [0:`NIDS_NUM_STREAMS-1];
   count_t     ref_user_count;
   count_t     ref_pass_count;
   count_t     ref_login_count;

   // Predictions waiting for their check slot
   count_t     exp_user_q [$];
   count_t     exp_pass_q [$];
   count_t     exp_login_q [$];
   bit         exp_alert_q [$];
   stream_id_t exp_stream_q [$];

   char_t       payload [$];
   logic [31:0] rng_state;
   int          cycle_count = 0;
   bit          checking = 1'b0;
   bit          eop_d1 = 1'b0;
   bit          eop_d2 = 1'b0;

   pop3_login_monitor u_pop3_login_monitor (
      .clk           (clk),
      .rst_n         (rst_n),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .stream_id     (stream_id),
      .eop           (eop),
      .user_enable   (user_enable),
      .pass_enable   (pass_enable),
      .user_count    (user_count),
      .pass_count    (pass_count),
      .login_alert   (login_alert),
      .alert_stream  (alert_stream),
      .login_count   (login_count)
   );

   // 8 ns period
   always #4 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic int unsigned rand_below(input int unsigned n);
      rng_state = xorshift32(rng_state);
      return rng_state % n;
   endfunction

   // One matcher step over a byte giving {accept, next state}
   function automatic logic [`NIDS_STATE_BITS:0] ref_step(input dfa_state_t s,
                                                          input char_t c, input string pat);
      char_t up;
      up = (c >= "a" && c <= "z") ? c - 8'h20 : c;
      if (up == pat[s])
      begin
         // Last character seen so report and start over
         if (s == dfa_state_t'(pat.len() - 1))
            return {1'b1, dfa_state_t'(0)};
         return {1'b0, s + dfa_state_t'(1)};
      end
      // A miss on the first letter of the pattern restarts at 1
      if (up == pat[0])
         return {1'b0, dfa_state_t'(1)};
      return '0;
   endfunction

   task automatic check_count(input string name, input count_t got, input count_t exp);
      if (got !== exp)
      begin
         $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "Wrong value on %s", name);
      end
   endtask

   task automatic check_stream(input string name, input stream_id_t got, input stream_id_t exp);
      if (got !== exp)
      begin
         $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "Wrong value on %s", name);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "Wrong value on %s", name);
      end
   endtask

   task automatic load_text(input string s);
      payload.delete();
      for (int i = 0; i < s.len(); i++)
         payload.push_back(s[i]);
   endtask

   // Loose bytes drawn mostly from pattern letters and spaces
   function automatic char_t random_byte();
      string letters;
      letters = "USERPAuserpa  ";
      if (rand_below(8) == 0)
         return char_t'(rand_below(256));
      return letters[rand_below(letters.len())];
   endfunction

   // Pieces of either pattern mixed with loose bytes so splits happen
   task automatic build_payload(input int len);
      string pat;
      int    first;
      int    last;
      char_t c;
      payload.delete();
      while (payload.size() < len)
      begin
         if (rand_below(3) == 0)
         begin
            if (rand_below(2) == 0)
               pat = "user ";
            else
               pat = "pass ";
            first = rand_below(5);
            last  = first + rand_below(5 - first);
            for (int i = first; i <= last; i++)
            begin
               c = pat[i];
               // Random letter case
               if (c != " " && rand_below(2) == 0)
                  c = c - 8'h20;
               payload.push_back(c);
            end
         end
         else
            payload.push_back(random_byte());
      end
   endtask

   // Sends the payload as one packet and predicts its results
   task automatic send_packet(input stream_id_t sid, input bit is_new, input bit u_en,
                              input bit p_en, input int gap_odds);
      dfa_state_t                us;
      dfa_state_t                ps;
      logic [`NIDS_STATE_BITS:0] step;
      bit                        uhit;
      bit                        phit;
      bit                        alert;
      us   = is_new ? dfa_state_t'(0) : ref_user_mem[sid];
      ps   = is_new ? dfa_state_t'(0) : ref_pass_mem[sid];
      uhit = 1'b0;
      phit = 1'b0;
      @(posedge clk);
      load_state    <= 1'b1;
      new_stream_id <= is_new;
      stream_id     <= sid;
      // Idle cycle while the contexts restore
      @(posedge clk);
      load_state    <= 1'b0;
      new_stream_id <= 1'b0;
      foreach (payload[i])
      begin
         // Occasional idle cycle inside the payload
         if (gap_odds != 0 && rand_below(gap_odds) == 0)
         begin
            @(posedge clk);
            char_in_vld <= 1'b0;
         end
         @(posedge clk);
         char_in     <= payload[i];
         char_in_vld <= 1'b1;
         step = ref_step(us, payload[i], "USER ");
         us   = step[`NIDS_STATE_BITS-1:0];
         uhit = uhit | step[`NIDS_STATE_BITS];
         step = ref_step(ps, payload[i], "PASS ");
         ps   = step[`NIDS_STATE_BITS-1:0];
         phit = phit | step[`NIDS_STATE_BITS];
      end
      // Idle cycle so the last accept lands before eop
      @(posedge clk);
      char_in_vld <= 1'b0;
      @(posedge clk);
      eop         <= 1'b1;
      user_enable <= u_en;
      pass_enable <= p_en;
      // Commit only what the enables allow
      alert = uhit && u_en && phit && p_en;
      if (u_en)
      begin
         ref_user_count = ref_user_count + count_t'(uhit);
         ref_user_mem[sid] = us;
         user_saved[sid] = 1'b1;
      end
      if (p_en)
      begin
         ref_pass_count = ref_pass_count + count_t'(phit);
         ref_pass_mem[sid] = ps;
         pass_saved[sid] = 1'b1;
      end
      if (alert)
         ref_login_count = ref_login_count + count_t'(1);
      exp_user_q.push_back(ref_user_count);
      exp_pass_q.push_back(ref_pass_count);
      exp_login_q.push_back(ref_login_count);
      exp_alert_q.push_back(alert);
      exp_stream_q.push_back(sid);
      @(posedge clk);
      eop <= 1'b0;
   endtask

   // Compare on falling edges two cycles after each eop
   always @(negedge clk)
   begin
      if (checking)
      begin
         if (eop_d2)
         begin
            check_count("user_count", user_count, exp_user_q.pop_front());
            check_count("pass_count", pass_count, exp_pass_q.pop_front());
            check_count("login_count", login_count, exp_login_q.pop_front());
            check_flag("login_alert", login_alert, exp_alert_q.pop_front());
            check_stream("alert_stream", alert_stream, exp_stream_q.pop_front());
         end
         // Alert is a pulse and stays low between reports
         else
            check_flag("login_alert", login_alert, 1'b0);
      end
      eop_d2 = eop_d1;
      eop_d1 = eop;
   end

   // Hang guard
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("Run did not complete within %0d cycles", CYCLE_LIMIT);
         $display("TESTBENCH FAILED");
         $fatal(1, "Timeout");
      end
   end

   initial
   begin
      stream_id_t sid;
      bit         is_new;
      bit         u_en;
      bit         p_en;
      rng_state       = 32'hd6cd;
      rst_n           = 1'b0;
      char_in         = '0;
      char_in_vld     = 1'b0;
      load_state      = 1'b0;
      new_stream_id   = 1'b0;
      stream_id       = '0;
      eop             = 1'b0;
      user_enable     = 1'b0;
      pass_enable     = 1'b0;
      ref_user_count  = '0;
      ref_pass_count  = '0;
      ref_login_count = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_count("user_count", user_count, '0);
      check_count("pass_count", pass_count, '0);
      check_count("login_count", login_count, '0);
      check_flag("login_alert", login_alert, 1'b0);
      checking = 1'b1;

      // Both commands in one packet of a new stream
      load_text("user x\r\npass y");
      send_packet(6'd1, 1'b1, 1'b1, 1'b1, 0);
      // USER split over two packets of one stream
      load_text("xUS");
      send_packet(6'd2, 1'b1, 1'b1, 1'b1, 0);
      load_text("ER q");
      send_packet(6'd2, 1'b0, 1'b1, 1'b1, 0);
      // Same split but the stream is announced as new
      load_text("US");
      send_packet(6'd3, 1'b1, 1'b1, 1'b1, 0);
      load_text("ER ");
      send_packet(6'd3, 1'b1, 1'b1, 1'b1, 0);
      // Disabled USER packet neither counts nor saves
      load_text("uS");
      send_packet(6'd4, 1'b1, 1'b1, 1'b1, 0);
      load_text("er pass ");
      send_packet(6'd4, 1'b0, 1'b0, 1'b1, 0);
      load_text("ER ");
      send_packet(6'd4, 1'b0, 1'b1, 1'b1, 0);

      // Random packets over 8 streams
      for (int n = 0; n < NUM_RANDOM; n++)
      begin
         sid = stream_id_t'(rand_below(8));
         // Unsaved slots must be cleared on load
         is_new = !(user_saved[sid] && pass_saved[sid]) || rand_below(16) == 0;
         u_en   = rand_below(4) != 0;
         p_en   = rand_below(4) != 0;
         build_payload(1 + rand_below(12));
         send_packet(sid, is_new, u_en, p_en, 4);
         repeat (rand_below(3)) @(posedge clk);
      end

      // Drain the last reports
      while (exp_user_q.size() != 0)
         @(posedge clk);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/nids_pkg.sv
hdl/pop3_user_dfa.sv
hdl/pop3_pass_dfa.sv
hdl/stream_match_context.sv
hdl/login_alert_combiner.sv
hdl/pop3_login_monitor.sv
testbench/tb_pop3_login_monitor.sv
